// File: Makefile
VERILATOR  = verilator
FILE_LIST  = tb.f
TOP        = lce_cmd_tb
OBJ_DIR    = obj_dir
LOG        = sim.log
COMMON     = --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILE_LIST)
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary --assert -j 0 -Mdir $(OBJ_DIR) $(COMMON)
FAIL_MSG   = SIMULATION FAILED
PASS_MSG   = SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

build:
	$(VERILATOR) $(SIM_FLAGS)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/lce_cfg.svh
// sizes of the instruction-cache agent command path, included by the package and the testbench
`ifndef LCE_CFG_SVH
`define LCE_CFG_SVH

// physical address and cache block
`define LCE_ADDR_W   22
`define LCE_BLOCK_W  64
`define LCE_OFFSET_W 3

// cache geometry
`define LCE_SETS     16
`define LCE_INDEX_W  4
`define LCE_WAYS     4
`define LCE_WAY_W    2

// tag is whatever remains above index and offset
`define LCE_TAG_W    (`LCE_ADDR_W - `LCE_INDEX_W - `LCE_OFFSET_W)

// agent and directory ids
`define LCE_ID_W     4
`define LCE_NUM_CCE  2

// shared by the set sweep and the sync count
`define LCE_CNT_W    5

`endif

// File: hdl/lce_cmd_ctrl.sv
// command FSM of the agent, decodes each command and drives every valid, yumi and status strobe
`include "lce_cfg.svh"

module lce_cmd_ctrl
  import lce_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       cmd_v_i,
  input  cmd_type_e  cmd_type_i,
  output logic       cmd_yumi_o,

  input  logic       tag_pkt_ready_i,
  input  logic       data_pkt_ready_i,
  input  logic       stat_pkt_ready_i,
  output logic       tag_pkt_v_o,
  output logic       data_pkt_v_o,
  output logic       stat_pkt_v_o,

  output tag_src_e   tag_src_o,
  output tag_op_e    tag_op_o,
  output data_op_e   data_op_o,
  output logic       stat_src_sweep_o,
  output index_t     sweep_idx_o,

  input  logic       resp_yumi_i,
  input  logic       inv_pending_i,
  output logic       resp_req_o,
  output resp_type_e resp_type_o,
  output logic       inv_fire_o,

  output logic       lce_ready_o,
  output logic       set_tag_received_o,
  output logic       set_tag_wakeup_received_o,
  output logic       cce_data_received_o,
  output logic       uncached_data_received_o,
  output logic       cache_req_complete_o
);

  localparam cnt_t LAST_SET = cnt_t'(`LCE_SETS - 1);
  localparam cnt_t LAST_CCE = cnt_t'(`LCE_NUM_CCE - 1);

  ctrl_state_e state_r;
  ctrl_state_e state_n;
  cnt_t        cnt_r;
  logic        cnt_inc;
  logic        cnt_clear;
  logic        tag_stat_rdy;
  logic        tag_data_rdy;
  logic        cached_ok;

  assign tag_stat_rdy = tag_pkt_ready_i & stat_pkt_ready_i;
  assign tag_data_rdy = tag_pkt_ready_i & data_pkt_ready_i;
  assign cached_ok    = (state_r == e_st_ready);

  assign sweep_idx_o = index_t'(cnt_r);
  assign lce_ready_o = (state_r != e_st_reset);

  always_comb begin
    state_n   = state_r;
    cnt_inc   = 1'b0;
    cnt_clear = 1'b0;

    cmd_yumi_o       = 1'b0;
    tag_pkt_v_o      = 1'b0;
    data_pkt_v_o     = 1'b0;
    stat_pkt_v_o     = 1'b0;
    tag_src_o        = e_tag_src_cmd;
    tag_op_o         = e_tag_set_clear;
    data_op_o        = e_data_write;
    stat_src_sweep_o = 1'b0;
    resp_req_o       = 1'b0;
    resp_type_o      = e_resp_sync_ack;
    inv_fire_o       = 1'b0;

    set_tag_received_o        = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o       = 1'b0;
    uncached_data_received_o  = 1'b0;
    cache_req_complete_o      = 1'b0;

    case (state_r)
      // clear one set of tags and status per cycle that both memories accept
      e_st_reset: begin
        tag_src_o        = e_tag_src_sweep;
        stat_src_sweep_o = 1'b1;
        tag_pkt_v_o      = tag_stat_rdy;
        stat_pkt_v_o     = tag_stat_rdy;
        if (tag_stat_rdy) begin
          if (cnt_r == LAST_SET) begin
            cnt_clear = 1'b1;
            state_n   = e_st_uncached_only;
          end else begin
            cnt_inc = 1'b1;
          end
        end
      end

      e_st_uncached_only, e_st_ready: begin
        if (cmd_v_i) begin
          case (cmd_type_i)
            e_cmd_set_clear: begin
              tag_pkt_v_o  = tag_stat_rdy;
              stat_pkt_v_o = tag_stat_rdy;
              cmd_yumi_o   = tag_stat_rdy;
            end

            e_cmd_uc_data: begin
              data_op_o                = e_data_uncached;
              data_pkt_v_o             = data_pkt_ready_i;
              cmd_yumi_o               = data_pkt_ready_i;
              uncached_data_received_o = data_pkt_ready_i;
              cache_req_complete_o     = data_pkt_ready_i;
            end

            // counter now tracks acknowledged directories
            e_cmd_sync: begin
              if (!cached_ok) begin
                resp_req_o = 1'b1;
                cmd_yumi_o = resp_yumi_i;
                if (resp_yumi_i) begin
                  if (cnt_r == LAST_CCE) begin
                    cnt_clear = 1'b1;
                    state_n   = e_st_ready;
                  end else begin
                    cnt_inc = 1'b1;
                  end
                end
              end
            end

            e_cmd_st: begin
              if (cached_ok) begin
                tag_op_o           = e_tag_set_state;
                tag_pkt_v_o        = tag_pkt_ready_i;
                cmd_yumi_o         = tag_pkt_ready_i;
                set_tag_received_o = tag_pkt_ready_i;
              end
            end

            e_cmd_st_wakeup: begin
              if (cached_ok) begin
                tag_op_o                  = e_tag_set_tag;
                tag_pkt_v_o               = tag_pkt_ready_i;
                cmd_yumi_o                = tag_pkt_ready_i;
                set_tag_wakeup_received_o = tag_pkt_ready_i;
                cache_req_complete_o      = tag_pkt_ready_i;
              end
            end

            // tag write once, then hold the ack until the directory takes it
            e_cmd_inv: begin
              if (cached_ok) begin
                tag_op_o    = e_tag_invalidate;
                tag_pkt_v_o = tag_pkt_ready_i & ~inv_pending_i;
                inv_fire_o  = tag_pkt_v_o;
                resp_req_o  = inv_fire_o;
                resp_type_o = e_resp_inv_ack;
                cmd_yumi_o  = resp_yumi_i & (inv_fire_o | inv_pending_i);
              end
            end

            e_cmd_data: begin
              if (cached_ok) begin
                tag_src_o            = e_tag_src_miss;
                tag_op_o             = e_tag_set_tag;
                tag_pkt_v_o          = tag_data_rdy;
                data_pkt_v_o         = tag_data_rdy;
                cmd_yumi_o           = tag_data_rdy;
                set_tag_received_o   = tag_data_rdy;
                cce_data_received_o  = tag_data_rdy;
                cache_req_complete_o = tag_data_rdy;
              end
            end

            e_cmd_wb: begin
              if (cached_ok) begin
                resp_req_o  = 1'b1;
                resp_type_o = e_resp_null_wb;
                cmd_yumi_o  = resp_yumi_i;
              end
            end

            default: begin
            end
          endcase
        end
      end

      default: begin
        state_n = e_st_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_st_reset;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (cnt_clear) begin
        cnt_r <= '0;
      end else if (cnt_inc) begin
        cnt_r <= cnt_r + cnt_t'(1);
      end
    end
  end

endmodule

// File: hdl/lce_cmd_top.sv
// top of the agent command path, instantiate this to attach commands to the cache memories
module lce_cmd_top
  import lce_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  // command from the directory
  input  logic       cmd_v_i,
  input  cmd_type_e  cmd_type_i,
  input  lce_id_t    cmd_src_i,
  input  addr_t      cmd_addr_i,
  input  way_t       cmd_way_i,
  input  coh_state_e cmd_state_i,
  input  block_t     cmd_data_i,
  output logic       cmd_yumi_o,

  input  addr_t      miss_addr_i,

  // tag memory
  output logic       tag_pkt_v_o,
  input  logic       tag_pkt_ready_i,
  output index_t     tag_pkt_index_o,
  output way_t       tag_pkt_way_o,
  output tag_t       tag_pkt_tag_o,
  output coh_state_e tag_pkt_state_o,
  output tag_op_e    tag_pkt_op_o,

  // data memory
  output logic       data_pkt_v_o,
  input  logic       data_pkt_ready_i,
  output index_t     data_pkt_index_o,
  output way_t       data_pkt_way_o,
  output block_t     data_pkt_data_o,
  output data_op_e   data_pkt_op_o,

  // status memory
  output logic       stat_pkt_v_o,
  input  logic       stat_pkt_ready_i,
  output index_t     stat_pkt_index_o,

  // response to the directory
  output logic       resp_v_o,
  input  logic       resp_yumi_i,
  output resp_type_e resp_type_o,
  output lce_id_t    resp_dst_o,
  output addr_t      resp_addr_o,

  output logic       lce_ready_o,
  output logic       set_tag_received_o,
  output logic       set_tag_wakeup_received_o,
  output logic       cce_data_received_o,
  output logic       uncached_data_received_o,
  output logic       cache_req_complete_o
);

  tag_src_e   tag_src;
  tag_op_e    tag_op;
  data_op_e   data_op;
  logic       stat_src_sweep;
  index_t     sweep_idx;
  logic       resp_req;
  resp_type_e resp_type_req;
  logic       inv_fire;
  logic       inv_pending;

  lce_cmd_ctrl lce_cmd_ctrl_inst (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .cmd_v_i                   (cmd_v_i),
    .cmd_type_i                (cmd_type_i),
    .cmd_yumi_o                (cmd_yumi_o),
    .tag_pkt_ready_i           (tag_pkt_ready_i),
    .data_pkt_ready_i          (data_pkt_ready_i),
    .stat_pkt_ready_i          (stat_pkt_ready_i),
    .tag_pkt_v_o               (tag_pkt_v_o),
    .data_pkt_v_o              (data_pkt_v_o),
    .stat_pkt_v_o              (stat_pkt_v_o),
    .tag_src_o                 (tag_src),
    .tag_op_o                  (tag_op),
    .data_op_o                 (data_op),
    .stat_src_sweep_o          (stat_src_sweep),
    .sweep_idx_o               (sweep_idx),
    .resp_yumi_i               (resp_yumi_i),
    .inv_pending_i             (inv_pending),
    .resp_req_o                (resp_req),
    .resp_type_o               (resp_type_req),
    .inv_fire_o                (inv_fire),
    .lce_ready_o               (lce_ready_o),
    .set_tag_received_o        (set_tag_received_o),
    .set_tag_wakeup_received_o (set_tag_wakeup_received_o),
    .cce_data_received_o       (cce_data_received_o),
    .uncached_data_received_o  (uncached_data_received_o),
    .cache_req_complete_o      (cache_req_complete_o)
  );

  lce_tag_pkt lce_tag_pkt_inst (
    .tag_src_i       (tag_src),
    .tag_op_i        (tag_op),
    .sweep_idx_i     (sweep_idx),
    .cmd_addr_i      (cmd_addr_i),
    .miss_addr_i     (miss_addr_i),
    .cmd_way_i       (cmd_way_i),
    .cmd_state_i     (cmd_state_i),
    .tag_pkt_index_o (tag_pkt_index_o),
    .tag_pkt_way_o   (tag_pkt_way_o),
    .tag_pkt_tag_o   (tag_pkt_tag_o),
    .tag_pkt_state_o (tag_pkt_state_o),
    .tag_pkt_op_o    (tag_pkt_op_o)
  );

  lce_fill_pkt lce_fill_pkt_inst (
    .data_op_i        (data_op),
    .stat_src_sweep_i (stat_src_sweep),
    .sweep_idx_i      (sweep_idx),
    .cmd_addr_i       (cmd_addr_i),
    .miss_addr_i      (miss_addr_i),
    .cmd_way_i        (cmd_way_i),
    .cmd_data_i       (cmd_data_i),
    .data_pkt_index_o (data_pkt_index_o),
    .data_pkt_way_o   (data_pkt_way_o),
    .data_pkt_data_o  (data_pkt_data_o),
    .data_pkt_op_o    (data_pkt_op_o),
    .stat_pkt_index_o (stat_pkt_index_o)
  );

  lce_resp_out lce_resp_out_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .resp_req_i    (resp_req),
    .resp_type_i   (resp_type_req),
    .inv_fire_i    (inv_fire),
    .cmd_src_i     (cmd_src_i),
    .cmd_addr_i    (cmd_addr_i),
    .resp_v_o      (resp_v_o),
    .resp_yumi_i   (resp_yumi_i),
    .resp_type_o   (resp_type_o),
    .resp_dst_o    (resp_dst_o),
    .resp_addr_o   (resp_addr_o),
    .inv_pending_o (inv_pending)
  );

endmodule

// File: hdl/lce_fill_pkt.sv
// forms the data memory fill packet and the status memory clear packet fields
`include "lce_cfg.svh"

module lce_fill_pkt
  import lce_pkg::*;
(
  input  data_op_e data_op_i,
  input  logic     stat_src_sweep_i,
  input  index_t   sweep_idx_i,
  input  addr_t    cmd_addr_i,
  input  addr_t    miss_addr_i,
  input  way_t     cmd_way_i,
  input  block_t   cmd_data_i,

  output index_t   data_pkt_index_o,
  output way_t     data_pkt_way_o,
  output block_t   data_pkt_data_o,
  output data_op_e data_pkt_op_o,
  output index_t   stat_pkt_index_o
);

  index_t cmd_index;

  assign cmd_index = cmd_addr_i[`LCE_OFFSET_W +: `LCE_INDEX_W];

  // fills always land in the set of the outstanding miss
  assign data_pkt_index_o = miss_addr_i[`LCE_OFFSET_W +: `LCE_INDEX_W];
  assign data_pkt_way_o   = cmd_way_i;
  assign data_pkt_data_o  = cmd_data_i;
  assign data_pkt_op_o    = data_op_i;

  assign stat_pkt_index_o = stat_src_sweep_i ? sweep_idx_i : cmd_index;

endmodule

// File: hdl/lce_pkg.sv
// types and encodings shared by the agent command path RTL and its testbench
`include "lce_cfg.svh"

package lce_pkg;

  typedef logic [`LCE_ADDR_W-1:0]  addr_t;
  typedef logic [`LCE_BLOCK_W-1:0] block_t;
  typedef logic [`LCE_INDEX_W-1:0] index_t;
  typedef logic [`LCE_WAY_W-1:0]   way_t;
  typedef logic [`LCE_TAG_W-1:0]   tag_t;
  typedef logic [`LCE_ID_W-1:0]    lce_id_t;
  typedef logic [`LCE_CNT_W-1:0]   cnt_t;

  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_e = 2'd2,
    e_coh_m = 2'd3
  } coh_state_e;

  // directory to agent commands
  typedef enum logic [3:0] {
    e_cmd_set_clear = 4'd0,
    e_cmd_sync      = 4'd1,
    e_cmd_uc_data   = 4'd2,
    e_cmd_st        = 4'd3,
    e_cmd_st_wakeup = 4'd4,
    e_cmd_inv       = 4'd5,
    e_cmd_data      = 4'd6,
    e_cmd_wb        = 4'd7
  } cmd_type_e;

  typedef enum logic [1:0] {
    e_resp_sync_ack = 2'd0,
    e_resp_inv_ack  = 2'd1,
    e_resp_null_wb  = 2'd2
  } resp_type_e;

  typedef enum logic [1:0] {
    e_tag_set_clear  = 2'd0,
    e_tag_set_state  = 2'd1,
    e_tag_set_tag    = 2'd2,
    e_tag_invalidate = 2'd3
  } tag_op_e;

  typedef enum logic {
    e_data_write    = 1'b0,
    e_data_uncached = 1'b1
  } data_op_e;

  // where the tag packet takes its set index from
  typedef enum logic [1:0] {
    e_tag_src_sweep = 2'd0,
    e_tag_src_cmd   = 2'd1,
    e_tag_src_miss  = 2'd2
  } tag_src_e;

  typedef enum logic [1:0] {
    e_st_reset         = 2'd0,
    e_st_uncached_only = 2'd1,
    e_st_ready         = 2'd2
  } ctrl_state_e;

endpackage

// File: hdl/lce_resp_out.sv
// forms the response to the directory and holds an invalidate ack until it is taken
module lce_resp_out
  import lce_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       resp_req_i,
  input  resp_type_e resp_type_i,
  input  logic       inv_fire_i,
  input  lce_id_t    cmd_src_i,
  input  addr_t      cmd_addr_i,

  output logic       resp_v_o,
  input  logic       resp_yumi_i,
  output resp_type_e resp_type_o,
  output lce_id_t    resp_dst_o,
  output addr_t      resp_addr_o,

  output logic       inv_pending_o
);

  logic inv_pending_r;

  // a pending ack keeps the response up after the tag write has gone
  assign resp_v_o      = resp_req_i | inv_pending_r;
  assign inv_pending_o = inv_pending_r;

  assign resp_type_o = resp_type_i;
  assign resp_dst_o  = cmd_src_i;
  assign resp_addr_o = cmd_addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inv_pending_r <= 1'b0;
    end else if (resp_v_o && resp_yumi_i) begin
      inv_pending_r <= 1'b0;
    end else if (inv_fire_i) begin
      inv_pending_r <= 1'b1;
    end
  end

endmodule

// File: hdl/lce_tag_pkt.sv
// forms the tag memory packet fields from the sweep index, the command or the miss address
`include "lce_cfg.svh"

module lce_tag_pkt
  import lce_pkg::*;
(
  input  tag_src_e   tag_src_i,
  input  tag_op_e    tag_op_i,
  input  index_t     sweep_idx_i,
  input  addr_t      cmd_addr_i,
  input  addr_t      miss_addr_i,
  input  way_t       cmd_way_i,
  input  coh_state_e cmd_state_i,

  output index_t     tag_pkt_index_o,
  output way_t       tag_pkt_way_o,
  output tag_t       tag_pkt_tag_o,
  output coh_state_e tag_pkt_state_o,
  output tag_op_e    tag_pkt_op_o
);

  index_t cmd_index;
  index_t miss_index;
  tag_t   cmd_tag;

  assign cmd_index  = cmd_addr_i[`LCE_OFFSET_W +: `LCE_INDEX_W];
  assign miss_index = miss_addr_i[`LCE_OFFSET_W +: `LCE_INDEX_W];
  assign cmd_tag    = cmd_addr_i[`LCE_OFFSET_W + `LCE_INDEX_W +: `LCE_TAG_W];

  always_comb begin
    case (tag_src_i)
      e_tag_src_cmd:  tag_pkt_index_o = cmd_index;
      e_tag_src_miss: tag_pkt_index_o = miss_index;
      default:        tag_pkt_index_o = sweep_idx_i;
    endcase
  end

  // clears and invalidates leave the line in I, clears also zero the tag
  assign tag_pkt_state_o = ((tag_op_i == e_tag_set_clear) || (tag_op_i == e_tag_invalidate))
                         ? e_coh_i : cmd_state_i;
  assign tag_pkt_tag_o   = (tag_op_i == e_tag_set_clear) ? '0 : cmd_tag;

  assign tag_pkt_way_o = cmd_way_i;
  assign tag_pkt_op_o  = tag_op_i;

endmodule

// File: tb.f
+incdir+hdl
hdl/lce_pkg.sv
hdl/lce_cmd_ctrl.sv
hdl/lce_tag_pkt.sv
hdl/lce_fill_pkt.sv
hdl/lce_resp_out.sv
hdl/lce_cmd_top.sv
tests/lce_cmd_props.sv
tests/lce_cmd_tb.sv

// File: tests/lce_cmd_props.sv
// concurrent checks on the handshakes of the command path top level, bound into lce_cmd_top
module lce_cmd_props
  import lce_pkg::*;
(
  input logic       clk_i,
  input logic       reset_i,
  input logic       cmd_v_i,
  input logic       cmd_yumi_o,
  input logic       tag_pkt_v_o,
  input logic       tag_pkt_ready_i,
  input logic       data_pkt_v_o,
  input logic       data_pkt_ready_i,
  input logic       stat_pkt_v_o,
  input logic       stat_pkt_ready_i,
  input logic       resp_v_o,
  input logic       resp_yumi_i,
  input resp_type_e resp_type_o,
  input lce_id_t    resp_dst_o,
  input addr_t      resp_addr_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // a packet is offered only while its memory can take it
  pkt_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (!tag_pkt_v_o || tag_pkt_ready_i) && (!data_pkt_v_o || data_pkt_ready_i)
      && (!stat_pkt_v_o || stat_pkt_ready_i))
    else $error("packet valid while its ready is low");

  yumi_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_o |-> cmd_v_i)
    else $error("command consumed while no command was offered");

  // an offered response holds until the directory takes it
  resp_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_type_o)
      && $stable(resp_dst_o) && $stable(resp_addr_o)))
    else $error("response dropped or changed before it was taken");

  // only the tag and status sweep may run right out of reset
  reset_quiet_a: assert property (@(posedge clk_i)
    reset_i |=> (!data_pkt_v_o && !resp_v_o && !cmd_yumi_o))
    else $error("data, response or yumi active in the cycle after reset");

endmodule

bind lce_cmd_top lce_cmd_props lce_cmd_props_inst (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .cmd_v_i          (cmd_v_i),
  .cmd_yumi_o       (cmd_yumi_o),
  .tag_pkt_v_o      (tag_pkt_v_o),
  .tag_pkt_ready_i  (tag_pkt_ready_i),
  .data_pkt_v_o     (data_pkt_v_o),
  .data_pkt_ready_i (data_pkt_ready_i),
  .stat_pkt_v_o     (stat_pkt_v_o),
  .stat_pkt_ready_i (stat_pkt_ready_i),
  .resp_v_o         (resp_v_o),
  .resp_yumi_i      (resp_yumi_i),
  .resp_type_o      (resp_type_o),
  .resp_dst_o       (resp_dst_o),
  .resp_addr_o      (resp_addr_o)
);

// File: tests/lce_cmd_tb.sv
// testbench for the agent command path, run it as top to drive directory commands and check packets
`include "lce_cfg.svh"

module lce_cmd_tb
  import lce_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CYCLE_LIMIT = 4000;
  localparam int N_RAND      = 24;

  typedef struct packed {
    index_t     tag_index;
    tag_t       tag_tag;
    coh_state_e tag_state;
    tag_op_e    tag_op;
    way_t       way;
    index_t     data_index;
    block_t     block;
    data_op_e   data_op;
    index_t     stat_index;
    resp_type_e resp_type;
    lce_id_t    dst;
    addr_t      addr;
    logic [4:0] pulses;
  } expect_t;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       cmd_v_i;
  cmd_type_e  cmd_type_i;
  lce_id_t    cmd_src_i;
  addr_t      cmd_addr_i;
  way_t       cmd_way_i;
  coh_state_e cmd_state_i;
  block_t     cmd_data_i;
  addr_t      miss_addr_i;
  logic       tag_pkt_ready_i  = 1'b0;
  logic       data_pkt_ready_i = 1'b0;
  logic       stat_pkt_ready_i = 1'b0;
  logic       resp_yumi_i      = 1'b0;

  logic       cmd_yumi_o;
  logic       tag_pkt_v_o;
  index_t     tag_pkt_index_o;
  way_t       tag_pkt_way_o;
  tag_t       tag_pkt_tag_o;
  coh_state_e tag_pkt_state_o;
  tag_op_e    tag_pkt_op_o;
  logic       data_pkt_v_o;
  index_t     data_pkt_index_o;
  way_t       data_pkt_way_o;
  block_t     data_pkt_data_o;
  data_op_e   data_pkt_op_o;
  logic       stat_pkt_v_o;
  index_t     stat_pkt_index_o;
  logic       resp_v_o;
  resp_type_e resp_type_o;
  lce_id_t    resp_dst_o;
  addr_t      resp_addr_o;
  logic       lce_ready_o;
  logic       set_tag_received_o;
  logic       set_tag_wakeup_received_o;
  logic       cce_data_received_o;
  logic       uncached_data_received_o;
  logic       cache_req_complete_o;

  integer     seed = 32'h4f45_1bbd;
  logic [31:0] rnd;
  int         cycles;
  int         mismatches;
  int         other_errors;
  int         sweep_cnt;
  int         tag_fires;
  int         data_fires;
  int         stat_fires;
  int         resp_takes;
  int         yumi_count;

  lce_id_t    src_tab [N_RAND];
  addr_t      addr_tab [N_RAND];
  addr_t      miss_tab [N_RAND];
  way_t       way_tab [N_RAND];
  coh_state_e state_tab [N_RAND];
  block_t     blk_tab [N_RAND];

  lce_cmd_top lce_cmd_top_inst (.*);

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  // expected packets and pulses for the command on the inputs, or for one sweep step
  function automatic expect_t expect_pkts(input logic sweep, input index_t sweep_idx,
                                          input cmd_type_e op, input lce_id_t src,
                                          input addr_t addr, input addr_t miss, input way_t way,
                                          input coh_state_e st, input block_t blk);
    expect_t e;
    index_t  cmd_idx;
    index_t  miss_idx;
    cmd_idx      = addr[`LCE_OFFSET_W +: `LCE_INDEX_W];
    miss_idx     = miss[`LCE_OFFSET_W +: `LCE_INDEX_W];
    e            = '0;
    e.way        = way;
    e.block      = blk;
    e.dst        = src;
    e.addr       = addr;
    e.tag_index  = cmd_idx;
    e.tag_tag    = addr[`LCE_ADDR_W-1 -: `LCE_TAG_W];
    e.tag_state  = st;
    e.data_index = miss_idx;
    e.data_op    = e_data_write;
    e.stat_index = cmd_idx;
    e.resp_type  = e_resp_sync_ack;
    if (sweep) begin
      e.tag_index  = sweep_idx;
      e.stat_index = sweep_idx;
      e.tag_tag    = '0;
      e.tag_state  = e_coh_i;
      e.tag_op     = e_tag_set_clear;
    end else begin
      // pulses are {set_tag, set_tag_wakeup, cce_data, uncached_data, complete}
      case (op)
        e_cmd_set_clear: begin
          e.tag_tag   = '0;
          e.tag_state = e_coh_i;
          e.tag_op    = e_tag_set_clear;
        end
        e_cmd_uc_data: begin
          e.data_op = e_data_uncached;
          e.pulses  = 5'b00011;
        end
        e_cmd_st: begin
          e.tag_op = e_tag_set_state;
          e.pulses = 5'b10000;
        end
        e_cmd_st_wakeup: begin
          e.tag_op = e_tag_set_tag;
          e.pulses = 5'b01001;
        end
        e_cmd_inv: begin
          e.tag_state = e_coh_i;
          e.tag_op    = e_tag_invalidate;
          e.resp_type = e_resp_inv_ack;
        end
        e_cmd_data: begin
          e.tag_index = miss_idx;
          e.tag_op    = e_tag_set_tag;
          e.pulses    = 5'b10101;
        end
        e_cmd_wb: begin
          e.resp_type = e_resp_null_wb;
        end
        default: begin
        end
      endcase
    end
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    mismatches++;
    $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic check_tag(input index_t idx, input way_t way, input tag_t tag,
                           input coh_state_e st, input tag_op_e op, input expect_t e);
    if (idx !== e.tag_index)
      report_mismatch("tag_pkt_index_o", 64'(idx), 64'(e.tag_index));
    if (way !== e.way)
      report_mismatch("tag_pkt_way_o", 64'(way), 64'(e.way));
    if (tag !== e.tag_tag)
      report_mismatch("tag_pkt_tag_o", 64'(tag), 64'(e.tag_tag));
    if (st !== e.tag_state)
      report_mismatch("tag_pkt_state_o", 64'(st), 64'(e.tag_state));
    if (op !== e.tag_op)
      report_mismatch("tag_pkt_op_o", 64'(op), 64'(e.tag_op));
  endtask

  task automatic check_data(input index_t idx, input way_t way, input block_t blk,
                            input data_op_e op, input expect_t e);
    if (idx !== e.data_index)
      report_mismatch("data_pkt_index_o", 64'(idx), 64'(e.data_index));
    if (way !== e.way)
      report_mismatch("data_pkt_way_o", 64'(way), 64'(e.way));
    if (blk !== e.block)
      report_mismatch("data_pkt_data_o", blk, e.block);
    if (op !== e.data_op)
      report_mismatch("data_pkt_op_o", 64'(op), 64'(e.data_op));
  endtask

  task automatic check_stat(input index_t idx, input expect_t e);
    if (idx !== e.stat_index)
      report_mismatch("stat_pkt_index_o", 64'(idx), 64'(e.stat_index));
  endtask

  task automatic check_resp(input resp_type_e typ, input lce_id_t dst, input addr_t addr,
                            input expect_t e);
    if (typ !== e.resp_type)
      report_mismatch("resp_type_o", 64'(typ), 64'(e.resp_type));
    if (dst !== e.dst)
      report_mismatch("resp_dst_o", 64'(dst), 64'(e.dst));
    if (addr !== e.addr)
      report_mismatch("resp_addr_o", 64'(addr), 64'(e.addr));
  endtask

  task automatic check_pulse(input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp)
      report_mismatch("status pulses", 64'(got), 64'(exp));
  endtask

  // memory readies and response yumi are high about three cycles in four
  always @(negedge clk_i) begin
    rnd = $random(seed);
    tag_pkt_ready_i  = rnd[0] | rnd[1];
    data_pkt_ready_i = rnd[2] | rnd[3];
    stat_pkt_ready_i = rnd[4] | rnd[5];
    resp_yumi_i      = rnd[6] | rnd[7];
  end

  always @(posedge clk_i) begin
    expect_t e;
    if (!reset_i) begin
      e = expect_pkts(sweep_cnt < `LCE_SETS, index_t'(sweep_cnt), cmd_type_i, cmd_src_i,
                      cmd_addr_i, miss_addr_i, cmd_way_i, cmd_state_i, cmd_data_i);
      if (lce_ready_o !== (sweep_cnt == `LCE_SETS))
        report_mismatch("lce_ready_o", 64'(lce_ready_o), 64'(sweep_cnt == `LCE_SETS));
      if (tag_pkt_v_o) begin
        check_tag(tag_pkt_index_o, tag_pkt_way_o, tag_pkt_tag_o, tag_pkt_state_o,
                  tag_pkt_op_o, e);
        tag_fires++;
      end
      if (data_pkt_v_o) begin
        check_data(data_pkt_index_o, data_pkt_way_o, data_pkt_data_o, data_pkt_op_o, e);
        data_fires++;
      end
      if (stat_pkt_v_o) begin
        check_stat(stat_pkt_index_o, e);
        stat_fires++;
      end
      if (resp_v_o)
        check_resp(resp_type_o, resp_dst_o, resp_addr_o, e);
      if (resp_v_o && resp_yumi_i)
        resp_takes++;
      if (cmd_yumi_o)
        yumi_count++;
      check_pulse({set_tag_received_o, set_tag_wakeup_received_o, cce_data_received_o,
                   uncached_data_received_o, cache_req_complete_o},
                  cmd_yumi_o ? e.pulses : 5'b0);
      if (tag_pkt_v_o && sweep_cnt < `LCE_SETS)
        sweep_cnt++;
    end
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic send_cmd(input cmd_type_e op, input lce_id_t src, input addr_t addr,
                          input way_t way, input coh_state_e st, input block_t blk,
                          input int n_tag, input int n_data, input int n_stat,
                          input int n_resp);
    int tag_base;
    int data_base;
    int stat_base;
    int resp_base;
    @(negedge clk_i);
    tag_base    = tag_fires;
    data_base   = data_fires;
    stat_base   = stat_fires;
    resp_base   = resp_takes;
    cmd_type_i  = op;
    cmd_src_i   = src;
    cmd_addr_i  = addr;
    cmd_way_i   = way;
    cmd_state_i = st;
    cmd_data_i  = blk;
    cmd_v_i     = 1'b1;
    do begin
      @(posedge clk_i);
    end while (cmd_yumi_o !== 1'b1);
    @(negedge clk_i);
    cmd_v_i = 1'b0;
    if (tag_fires - tag_base != n_tag || data_fires - data_base != n_data
        || stat_fires - stat_base != n_stat || resp_takes - resp_base != n_resp) begin
      other_errors++;
      $display("%s command gave %0d tag, %0d data, %0d status packets, %0d responses",
               op.name(), tag_fires - tag_base, data_fires - data_base,
               stat_fires - stat_base, resp_takes - resp_base);
    end
  endtask

  task automatic expect_ignored(input cmd_type_e op, input addr_t addr, input int n_cycles);
    int yumi_base;
    int tag_base;
    @(negedge clk_i);
    yumi_base  = yumi_count;
    tag_base   = tag_fires;
    cmd_type_i = op;
    cmd_addr_i = addr;
    cmd_v_i    = 1'b1;
    repeat (n_cycles) @(negedge clk_i);
    cmd_v_i = 1'b0;
    if (yumi_count != yumi_base || tag_fires != tag_base) begin
      other_errors++;
      $display("%s command was accepted before both directories had synced", op.name());
    end
  endtask

  initial begin
    reset_i     = 1'b1;
    cmd_v_i     = 1'b0;
    cmd_type_i  = e_cmd_set_clear;
    cmd_src_i   = '0;
    cmd_addr_i  = '0;
    cmd_way_i   = '0;
    cmd_state_i = e_coh_i;
    cmd_data_i  = '0;
    miss_addr_i = '0;
    for (int i = 0; i < N_RAND; i++) begin
      src_tab[i]   = lce_id_t'($random(seed));
      addr_tab[i]  = addr_t'($random(seed));
      miss_tab[i]  = addr_t'($random(seed));
      way_tab[i]   = way_t'($random(seed));
      state_tab[i] = coh_state_e'(2'($random(seed)));
      blk_tab[i]   = {$random(seed), $random(seed)};
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    while (sweep_cnt < `LCE_SETS) @(negedge clk_i);
    @(negedge clk_i);
    if (tag_fires != `LCE_SETS || stat_fires != `LCE_SETS || data_fires != 0) begin
      other_errors++;
      $display("reset sweep gave %0d tag and %0d status clears instead of %0d each",
               tag_fires, stat_fires, `LCE_SETS);
    end

    // uncached traffic only until both directories have synced
    expect_ignored(e_cmd_st, addr_tab[0], 16);
    send_cmd(e_cmd_set_clear, 4'd1, 22'h0_0148, 2'd3, e_coh_m, '0, 1, 0, 1, 0);
    miss_addr_i = 22'h2_a5f0;
    send_cmd(e_cmd_uc_data, 4'd1, 22'h2_a5f0, 2'd1, e_coh_i, 64'h0123_4567_89ab_cdef,
             0, 1, 0, 0);
    send_cmd(e_cmd_sync, 4'd2, 22'h0_0000, 2'd0, e_coh_i, '0, 0, 0, 0, 1);
    send_cmd(e_cmd_sync, 4'd5, 22'h0_0000, 2'd0, e_coh_i, '0, 0, 0, 0, 1);
    send_cmd(e_cmd_st, src_tab[0], addr_tab[0], way_tab[0], e_coh_s, '0, 1, 0, 0, 0);

    for (int i = 0; i < N_RAND; i++) begin
      miss_addr_i = miss_tab[i];
      case (i % 3)
        0: send_cmd(e_cmd_st, src_tab[i], addr_tab[i], way_tab[i], state_tab[i],
                    blk_tab[i], 1, 0, 0, 0);
        1: send_cmd(e_cmd_st_wakeup, src_tab[i], addr_tab[i], way_tab[i], state_tab[i],
                    blk_tab[i], 1, 0, 0, 0);
        default: send_cmd(e_cmd_data, src_tab[i], addr_tab[i], way_tab[i], state_tab[i],
                          blk_tab[i], 1, 1, 0, 0);
      endcase
    end

    send_cmd(e_cmd_inv, src_tab[1], addr_tab[1], way_tab[1], e_coh_m, '0, 1, 0, 0, 1);
    send_cmd(e_cmd_inv, src_tab[2], addr_tab[2], way_tab[2], e_coh_e, '0, 1, 0, 0, 1);
    send_cmd(e_cmd_wb, src_tab[3], addr_tab[3], way_tab[3], e_coh_s, '0, 0, 0, 0, 1);

    repeat (2) @(negedge clk_i);
    $display("run ended with %0d value errors and %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
